/* Makefile */
TOP = softusb_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/softusb_config.svh */
`ifndef SOFTUSB_CONFIG_SVH
`define SOFTUSB_CONFIG_SVH

// clocks per bit, 48 MHz usb_clk gives 12 Mbit/s
`define SOFTUSB_OVERSAMPLE 4

// consecutive SE0 clocks before a port reads as disconnected
`define SOFTUSB_DISCON_CYCLES 120

// word address bits that select a register
`define SOFTUSB_ADDR_LSB 2
`define SOFTUSB_ADDR_MSB 5

`endif

/* sim.f */
+incdir+include
source/softusb_pkg.sv
source/softusb_tx.sv
source/softusb_rx.sv
source/softusb_phy.sv
source/softusb_sie.sv
verif/softusb_tb.sv

/* source/softusb_phy.sv */
`include "softusb_config.svh"

module softusb_phy (
	input  logic                     usb_clk,
	input  logic                     rst_n_i,
	output logic                     usba_spd_o,
	output logic                     usba_oe_n_o,
	input  logic                     usba_rcv_i,
	inout  wire                      usba_vp_io,
	inout  wire                      usba_vm_io,
	output logic                     usbb_spd_o,
	output logic                     usbb_oe_n_o,
	input  logic                     usbb_rcv_i,
	inout  wire                      usbb_vp_io,
	inout  wire                      usbb_vm_io,
	input  logic                     port_sel_rx_i,
	input  logic [1:0]               port_sel_tx_i,
	input  logic [7:0]               tx_data_i,
	input  logic                     tx_valid_i,
	output logic                     tx_ready_o,
	input  logic                     generate_reset_i,
	output logic [7:0]               rx_data_o,
	output logic                     rx_valid_o,
	output logic                     rx_active_o,
	output logic                     rx_error_o,
	output softusb_pkg::line_state_e line_state_a_o,
	output softusb_pkg::line_state_e line_state_b_o,
	output logic                     discon_a_o,
	output logic                     discon_b_o
);

	import softusb_pkg::*;

	localparam int dc_w = $clog2(`SOFTUSB_DISCON_CYCLES + 1);
	localparam logic [dc_w-1:0] dc_max = dc_w'(`SOFTUSB_DISCON_CYCLES);

	logic [1:0]      pin_vp;
	logic [1:0]      pin_vm;
	logic [1:0]      pin_rcv;
	logic [2:0]      sync_q1 [2];
	logic [2:0]      sync_q2 [2];
	line_state_e     line_st [2];
	logic [dc_w-1:0] se0_cnt [2];
	logic [1:0]      port_oe;
	line_state_e     tx_line;
	line_state_e     drv_line;
	logic            tx_drive;

	// single ended pair for SE0/SE1, differential receiver for J/K
	function automatic line_state_e decode_line(input logic [2:0] s);
		line_state_e ls;
		if (!s[2] && !s[1])
			ls = LINE_SE0;
		else if (s[2] && s[1])
			ls = LINE_SE1;
		else if (s[0])
			ls = LINE_J;
		else
			ls = LINE_K;
		return ls;
	endfunction

	assign pin_vp = {usbb_vp_io, usba_vp_io};
	assign pin_vm = {usbb_vm_io, usba_vm_io};
	assign pin_rcv = {usbb_rcv_i, usba_rcv_i};

	// {vp, vm, rcv} per port, comes out of reset as idle J
	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 2; i++) begin
				sync_q1[i] <= 3'b101;
				sync_q2[i] <= 3'b101;
				se0_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				sync_q1[i] <= {pin_vp[i], pin_vm[i], pin_rcv[i]};
				sync_q2[i] <= sync_q1[i];
				if (line_st[i] != LINE_SE0)
					se0_cnt[i] <= '0;
				else if (se0_cnt[i] != dc_max)
					se0_cnt[i] <= se0_cnt[i] + 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++)
			line_st[i] = decode_line(sync_q2[i]);
	end

	assign line_state_a_o = line_st[0];
	assign line_state_b_o = line_st[1];
	assign discon_a_o = (se0_cnt[0] == dc_max);
	assign discon_b_o = (se0_cnt[1] == dc_max);

	// bus reset overrides the tx engine on every enabled port
	assign drv_line = generate_reset_i ? LINE_SE0 : tx_line;
	assign port_oe = port_sel_tx_i & {2{tx_drive | generate_reset_i}};

	assign usba_spd_o = 1'b1;
	assign usbb_spd_o = 1'b1;
	assign usba_oe_n_o = ~port_oe[0];
	assign usbb_oe_n_o = ~port_oe[1];
	assign usba_vp_io = port_oe[0] ? drv_line[1] : 1'bz;
	assign usba_vm_io = port_oe[0] ? drv_line[0] : 1'bz;
	assign usbb_vp_io = port_oe[1] ? drv_line[1] : 1'bz;
	assign usbb_vm_io = port_oe[1] ? drv_line[0] : 1'bz;

	softusb_tx softusb_tx_inst (
		.usb_clk (usb_clk),
		.rst_n_i (rst_n_i),
		.data_i  (tx_data_i),
		.valid_i (tx_valid_i),
		.ready_o (tx_ready_o),
		.line_o  (tx_line),
		.drive_o (tx_drive)
	);

	softusb_rx softusb_rx_inst (
		.usb_clk  (usb_clk),
		.rst_n_i  (rst_n_i),
		.line_i   (port_sel_rx_i ? line_st[1] : line_st[0]),
		.data_o   (rx_data_o),
		.valid_o  (rx_valid_o),
		.active_o (rx_active_o),
		.error_o  (rx_error_o)
	);

endmodule

/* source/softusb_pkg.sv */
package softusb_pkg;

	// register map, one 32-bit word per register
	typedef enum logic [3:0] {
		REG_LINE_A     = 4'd0,
		REG_LINE_B     = 4'd1,
		REG_DISCON_A   = 4'd2,
		REG_DISCON_B   = 4'd3,
		REG_SEL_RX     = 4'd4,
		REG_SEL_TX     = 4'd5,
		REG_TX_DATA    = 4'd6,
		REG_TX_PENDING = 4'd7,
		REG_TX_VALID   = 4'd8,
		REG_GEN_RESET  = 4'd9,
		REG_RX_DATA    = 4'd10,
		REG_RX_PENDING = 4'd11,
		REG_RX_ACTIVE  = 4'd12,
		REG_RX_ERROR   = 4'd13
	} sie_reg_e;

	// encoded as {vp, vm}
	typedef enum logic [1:0] {
		LINE_SE0 = 2'b00,
		LINE_K   = 2'b01,
		LINE_J   = 2'b10,
		LINE_SE1 = 2'b11
	} line_state_e;

	// data byte in the top byte lane
	typedef struct packed {
		logic [7:0]  data;
		logic [23:0] pad;
	} sie_byte_t;

	// flag field at bits 25..24
	typedef struct packed {
		logic [5:0]  pad_hi;
		logic [1:0]  flags;
		logic [23:0] pad_lo;
	} sie_flag_t;

	typedef union packed {
		sie_byte_t as_byte;
		sie_flag_t as_flag;
	} sie_word_u;

endpackage

/* source/softusb_rx.sv */
`include "softusb_config.svh"

module softusb_rx (
	input  logic                     usb_clk,
	input  logic                     rst_n_i,
	input  softusb_pkg::line_state_e line_i,
	output logic [7:0]               data_o,
	output logic                     valid_o,
	output logic                     active_o,
	output logic                     error_o
);

	import softusb_pkg::*;

	localparam int ph_w = $clog2(`SOFTUSB_OVERSAMPLE);
	localparam logic [ph_w-1:0] ph_last = ph_w'(`SOFTUSB_OVERSAMPLE - 1);
	localparam logic [ph_w-1:0] ph_sample = ph_w'(`SOFTUSB_OVERSAMPLE / 2);

	line_state_e line_q;
	// level of the last J/K sample, for NRZI
	line_state_e last_lvl;
	logic [ph_w-1:0] phase;
	logic [2:0]  cnt;
	logic [2:0]  ones;
	logic [1:0]  zeros;
	logic [7:0]  sr;
	logic        sample;
	logic        is_jk;
	logic        bit_val;
	logic        take_bit;
	logic        se0_partial;
	logic        stuff_err;

	always_comb begin
		// no sample on a cycle that moves the line
		sample = (phase == ph_sample) && (line_i == line_q);
		is_jk = (line_i == LINE_J) || (line_i == LINE_K);
		bit_val = (line_i == last_lvl);
		take_bit = sample && active_o && is_jk && (ones != 3'd6);
		se0_partial = (line_i == LINE_SE0) && (cnt != 3'd0);
		stuff_err = is_jk && (ones == 3'd6) && bit_val;
	end

	// pulses while active is still high
	assign error_o = sample && active_o && (se0_partial || stuff_err);

	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			line_q <= LINE_J;
			last_lvl <= LINE_J;
			phase <= '0;
			cnt <= '0;
			ones <= '0;
			zeros <= '0;
			valid_o <= 1'b0;
			active_o <= 1'b0;
		end else begin
			line_q <= line_i;
			valid_o <= 1'b0;

			// resync on each transition
			if (line_i != line_q)
				phase <= ph_w'(1);
			else if (phase == ph_last)
				phase <= '0;
			else
				phase <= phase + 1'b1;

			if (sample && line_i == LINE_SE0) begin
				active_o <= 1'b0;
				last_lvl <= LINE_J;
				cnt <= '0;
				ones <= '0;
				zeros <= '0;
			end else if (sample && is_jk) begin
				last_lvl <= line_i;
				if (!active_o) begin
					// SYNC is a run of zeros closed by K K
					if (bit_val) begin
						if (zeros == 2'd3) begin
							active_o <= 1'b1;
							ones <= 3'd1;
							cnt <= '0;
						end
						zeros <= '0;
					end else if (zeros != 2'd3) begin
						zeros <= zeros + 1'b1;
					end
				end else if (ones == 3'd6) begin
					// drop the stuffed bit
					ones <= '0;
				end else begin
					ones <= bit_val ? ones + 1'b1 : 3'd0;
					cnt <= cnt + 1'b1;
					if (cnt == 3'd7)
						valid_o <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// byte assembly, LSB first
	////////////////////////////////////////
	always_ff @(posedge usb_clk) begin
		if (take_bit)
			sr <= {bit_val, sr[7:1]};
		if (take_bit && cnt == 3'd7)
			data_o <= {bit_val, sr[7:1]};
	end

endmodule

/* source/softusb_sie.sv */
`include "softusb_config.svh"

module softusb_sie (
	input  logic        usb_clk,
	input  logic        rst_n_i,

	input  logic        zpu_re_i,
	input  logic        zpu_we_i,
	input  logic [31:0] zpu_a_i,
	input  logic [31:0] zpu_dat_i,
	output logic [31:0] zpu_dat_o,

	output logic        usba_spd_o,
	output logic        usba_oe_n_o,
	input  logic        usba_rcv_i,
	inout  wire         usba_vp_io,
	inout  wire         usba_vm_io,

	output logic        usbb_spd_o,
	output logic        usbb_oe_n_o,
	input  logic        usbb_rcv_i,
	inout  wire         usbb_vp_io,
	inout  wire         usbb_vm_io
);

	import softusb_pkg::*;

	line_state_e line_state_a;
	line_state_e line_state_b;
	logic        discon_a;
	logic        discon_b;

	logic        port_sel_rx;
	logic [1:0]  port_sel_tx;
	logic        generate_reset;

	logic [7:0]  utmi_data_out;
	logic        utmi_tx_valid;
	logic        utmi_tx_ready;
	logic        tx_pending;

	logic [7:0]  utmi_data_in;
	logic        utmi_rx_valid;
	logic        utmi_rx_active;
	logic        utmi_rx_error;

	logic [7:0]  rx_data;
	logic        rx_pending;
	logic        rx_active_q;
	logic        rx_error;

	sie_reg_e    reg_sel;
	sie_word_u   wr_word;
	sie_word_u   rd_word;
	logic        rd_hit;

	assign reg_sel = sie_reg_e'(zpu_a_i[`SOFTUSB_ADDR_MSB:`SOFTUSB_ADDR_LSB]);
	assign wr_word = zpu_dat_i;

	////////////////////////////////////////
	// read mux
	////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		rd_hit = 1'b1;
		case (reg_sel)
			REG_LINE_A:     rd_word.as_flag.flags = line_state_a;
			REG_LINE_B:     rd_word.as_flag.flags = line_state_b;
			REG_DISCON_A:   rd_word.as_flag.flags = {1'b0, discon_a};
			REG_DISCON_B:   rd_word.as_flag.flags = {1'b0, discon_b};
			REG_SEL_RX:     rd_word.as_flag.flags = {1'b0, port_sel_rx};
			REG_SEL_TX:     rd_word.as_flag.flags = port_sel_tx;
			REG_TX_DATA:    rd_word.as_byte.data = utmi_data_out;
			REG_TX_PENDING: rd_word.as_flag.flags = {1'b0, tx_pending};
			REG_TX_VALID:   rd_word.as_flag.flags = {1'b0, utmi_tx_valid};
			REG_GEN_RESET:  rd_word.as_flag.flags = {1'b0, generate_reset};
			REG_RX_DATA:    rd_word.as_byte.data = rx_data;
			REG_RX_PENDING: rd_word.as_flag.flags = {1'b0, rx_pending};
			REG_RX_ACTIVE:  rd_word.as_flag.flags = {1'b0, utmi_rx_active};
			REG_RX_ERROR:   rd_word.as_flag.flags = {1'b0, rx_error};
			// unmapped words keep the last read value
			default:        rd_hit = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// register block
	////////////////////////////////////////

	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			zpu_dat_o <= '0;
			port_sel_rx <= 1'b0;
			port_sel_tx <= 2'b00;
			generate_reset <= 1'b0;
			utmi_data_out <= '0;
			utmi_tx_valid <= 1'b0;
			tx_pending <= 1'b0;
			rx_data <= '0;
			rx_pending <= 1'b0;
			rx_active_q <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			if (rd_hit)
				zpu_dat_o <= rd_word;
			if (zpu_re_i && reg_sel == REG_RX_DATA)
				rx_pending <= 1'b0;

			if (zpu_we_i) begin
				case (reg_sel)
					REG_SEL_RX:    port_sel_rx <= wr_word.as_flag.flags[0];
					REG_SEL_TX:    port_sel_tx <= wr_word.as_flag.flags;
					REG_TX_DATA: begin
						utmi_data_out <= wr_word.as_byte.data;
						utmi_tx_valid <= 1'b1;
						tx_pending <= 1'b1;
					end
					REG_TX_VALID:  utmi_tx_valid <= 1'b0;
					REG_GEN_RESET: generate_reset <= wr_word.as_flag.flags[0];
					default: ;
				endcase
			end

			// byte taken by the tx engine
			if (utmi_tx_ready)
				tx_pending <= 1'b0;

			// a new byte overwrites an unread one
			if (utmi_rx_valid) begin
				rx_data <= utmi_data_in;
				rx_pending <= 1'b1;
			end

			// error flag lives for one packet
			rx_active_q <= utmi_rx_active;
			if (utmi_rx_active && !rx_active_q)
				rx_error <= 1'b0;
			if (utmi_rx_active && utmi_rx_error)
				rx_error <= 1'b1;
		end
	end

	softusb_phy softusb_phy_inst (
		.usb_clk          (usb_clk),
		.rst_n_i          (rst_n_i),
		.usba_spd_o       (usba_spd_o),
		.usba_oe_n_o      (usba_oe_n_o),
		.usba_rcv_i       (usba_rcv_i),
		.usba_vp_io       (usba_vp_io),
		.usba_vm_io       (usba_vm_io),
		.usbb_spd_o       (usbb_spd_o),
		.usbb_oe_n_o      (usbb_oe_n_o),
		.usbb_rcv_i       (usbb_rcv_i),
		.usbb_vp_io       (usbb_vp_io),
		.usbb_vm_io       (usbb_vm_io),
		.port_sel_rx_i    (port_sel_rx),
		.port_sel_tx_i    (port_sel_tx),
		.tx_data_i        (utmi_data_out),
		.tx_valid_i       (utmi_tx_valid),
		.tx_ready_o       (utmi_tx_ready),
		.generate_reset_i (generate_reset),
		.rx_data_o        (utmi_data_in),
		.rx_valid_o       (utmi_rx_valid),
		.rx_active_o      (utmi_rx_active),
		.rx_error_o       (utmi_rx_error),
		.line_state_a_o   (line_state_a),
		.line_state_b_o   (line_state_b),
		.discon_a_o       (discon_a),
		.discon_b_o       (discon_b)
	);

endmodule

/* source/softusb_tx.sv */
`include "softusb_config.svh"

module softusb_tx (
	input  logic                     usb_clk,
	input  logic                     rst_n_i,
	input  logic [7:0]               data_i,
	input  logic                     valid_i,
	output logic                     ready_o,
	output softusb_pkg::line_state_e line_o,
	output logic                     drive_o
);

	import softusb_pkg::*;

	localparam int ph_w = $clog2(`SOFTUSB_OVERSAMPLE);
	localparam logic [ph_w-1:0] ph_last = ph_w'(`SOFTUSB_OVERSAMPLE - 1);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_SYNC,
		TX_DATA,
		TX_EOP_SE0,
		TX_EOP_J
	} tx_state_e;

	tx_state_e   state;
	logic [ph_w-1:0] phase;
	// sync bit index, data bits sent, or eop bit index
	logic [3:0]  cnt;
	logic [2:0]  ones;
	logic        have_next;
	logic [7:0]  sr;
	logic        bit_start;
	logic        data_slot;
	logic        byte_done;
	logic        more;
	logic        send_bit;
	line_state_e line_toggled;

	always_comb begin
		bit_start = (phase == ph_last);
		line_toggled = (line_o == LINE_J) ? LINE_K : LINE_J;
		// the slot after the closing K of SYNC carries data bit 0
		data_slot = bit_start && (state == TX_DATA || (state == TX_SYNC && cnt == 4'd7));
		byte_done = (state == TX_SYNC) || (cnt == 4'd8);
		more = (state == TX_SYNC) || have_next;
		send_bit = data_slot && (ones != 3'd6) && !(byte_done && !more);
	end

	always_ff @(posedge usb_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= TX_IDLE;
			phase <= '0;
			cnt <= '0;
			ones <= '0;
			have_next <= 1'b0;
			ready_o <= 1'b0;
			line_o <= LINE_J;
			drive_o <= 1'b0;
		end else begin
			ready_o <= 1'b0;
			if (state == TX_IDLE || bit_start)
				phase <= '0;
			else
				phase <= phase + 1'b1;

			case (state)
				TX_IDLE: begin
					ones <= '0;
					have_next <= 1'b0;
					if (valid_i) begin
						state <= TX_SYNC;
						line_o <= LINE_K;
						drive_o <= 1'b1;
						ready_o <= 1'b1;
						cnt <= '0;
					end
				end
				TX_SYNC: begin
					if (bit_start && cnt != 4'd7) begin
						cnt <= cnt + 1'b1;
						if (cnt == 4'd6)
							ones <= 3'd1;
						else
							line_o <= line_toggled;
					end
				end
				TX_EOP_SE0: begin
					if (bit_start) begin
						cnt <= cnt + 1'b1;
						if (cnt == 4'd1) begin
							state <= TX_EOP_J;
							line_o <= LINE_J;
						end
					end
				end
				TX_EOP_J: begin
					if (bit_start) begin
						state <= TX_IDLE;
						drive_o <= 1'b0;
					end
				end
				default: ;
			endcase

			////////////////////////////////////////
			// data bit slots
			////////////////////////////////////////
			if (data_slot) begin
				state <= TX_DATA;
				if (ones == 3'd6) begin
					// stuffed zero
					line_o <= line_toggled;
					ones <= '0;
				end else if (byte_done && !more) begin
					state <= TX_EOP_SE0;
					line_o <= LINE_SE0;
					cnt <= '0;
				end else begin
					if (sr[0]) begin
						ones <= ones + 1'b1;
					end else begin
						line_o <= line_toggled;
						ones <= '0;
					end
					cnt <= byte_done ? 4'd1 : cnt + 1'b1;
					// last bit starts, ask for the next byte
					if (!byte_done && cnt == 4'd7) begin
						ready_o <= valid_i;
						have_next <= valid_i;
					end
				end
			end
		end
	end

	// byte is taken while ready is high
	always_ff @(posedge usb_clk) begin
		if (ready_o)
			sr <= data_i;
		else if (send_bit)
			sr <= {1'b0, sr[7:1]};
	end

endmodule

/* verif/softusb_tb.sv */
`include "softusb_config.svh"

module softusb_tb;

	import softusb_pkg::*;

	localparam int clk_period = 40;
	localparam int drive_delay = 2;
	localparam int num_packets = 8;
	localparam int max_len = 6;
	localparam int margin_clocks = 5000;
	// 40 bit times per byte covers SYNC, stuffing, EOP and bus polling
	localparam int watchdog_time =
		(num_packets * max_len * 40 * `SOFTUSB_OVERSAMPLE + margin_clocks) * clk_period;

	logic        usb_clk;
	logic        rst_n_i;
	logic        zpu_re_i;
	logic        zpu_we_i;
	logic [31:0] zpu_a_i;
	logic [31:0] zpu_dat_i;
	logic [31:0] zpu_dat_o;
	logic        usba_spd_o;
	logic        usba_oe_n_o;
	logic        usba_rcv_i;
	logic        usbb_spd_o;
	logic        usbb_oe_n_o;
	logic        usbb_rcv_i;
	wire         usba_vp;
	wire         usba_vm;
	wire         usbb_vp;
	wire         usbb_vm;
	logic        force_se0;

	// bytes written for transmit, oldest first
	logic [7:0]  expected_q[$];
	logic [7:0]  pkt[$];

	////////////////////////////////////////
	// line loopback, port A to port B
	////////////////////////////////////////

	// pull-up gives idle J while A is not driven
	assign usba_vp = usba_oe_n_o ? 1'b1 : 1'bz;
	assign usba_vm = usba_oe_n_o ? 1'b0 : 1'bz;
	assign usbb_vp = usbb_oe_n_o ? (usba_vp & ~force_se0) : 1'bz;
	assign usbb_vm = usbb_oe_n_o ? (usba_vm & ~force_se0) : 1'bz;
	assign usba_rcv_i = usba_vp;
	assign usbb_rcv_i = usbb_vp;

	softusb_sie softusb_sie_inst (
		.usb_clk     (usb_clk),
		.rst_n_i     (rst_n_i),
		.zpu_re_i    (zpu_re_i),
		.zpu_we_i    (zpu_we_i),
		.zpu_a_i     (zpu_a_i),
		.zpu_dat_i   (zpu_dat_i),
		.zpu_dat_o   (zpu_dat_o),
		.usba_spd_o  (usba_spd_o),
		.usba_oe_n_o (usba_oe_n_o),
		.usba_rcv_i  (usba_rcv_i),
		.usba_vp_io  (usba_vp),
		.usba_vm_io  (usba_vm),
		.usbb_spd_o  (usbb_spd_o),
		.usbb_oe_n_o (usbb_oe_n_o),
		.usbb_rcv_i  (usbb_rcv_i),
		.usbb_vp_io  (usbb_vp),
		.usbb_vm_io  (usbb_vm)
	);

	initial begin
		usb_clk = 1'b0;
		forever #(clk_period / 2) usb_clk = ~usb_clk;
	end

	initial begin
		#(watchdog_time);
		$display("watchdog expired before all tests completed");
		$display("Regression failed");
		$fatal(1, "timeout");
	end

	// inputs change a little after the rising edge
	task automatic tick();
		@(posedge usb_clk);
		#drive_delay;
	endtask

	task automatic check_value(input string name, input logic [7:0] got,
			input logic [7:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, expected);
			$display("Regression failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	////////////////////////////////////////
	// bus access
	////////////////////////////////////////

	task automatic write_reg(input sie_reg_e r, input logic [7:0] val);
		sie_word_u word;
		word = '0;
		if (r == REG_TX_DATA) begin
			word.as_byte.data = val;
			expected_q.push_back(val);
		end else begin
			word.as_flag.flags = val[1:0];
		end
		zpu_a_i = 32'(r) << `SOFTUSB_ADDR_LSB;
		zpu_dat_i = word;
		zpu_we_i = 1'b1;
		tick();
		zpu_we_i = 1'b0;
	endtask

	// data appears one clock after the address
	task automatic read_reg(input sie_reg_e r, output logic [7:0] val);
		sie_word_u word;
		zpu_a_i = 32'(r) << `SOFTUSB_ADDR_LSB;
		zpu_re_i = 1'b1;
		tick();
		zpu_re_i = 1'b0;
		word = zpu_dat_o;
		if (r == REG_TX_DATA || r == REG_RX_DATA)
			val = word.as_byte.data;
		else
			val = {6'b0, word.as_flag.flags};
	endtask

	task automatic poll_flag(input sie_reg_e r, input logic [7:0] want);
		logic [7:0] v;
		read_reg(r, v);
		while (v !== want)
			read_reg(r, v);
	endtask

	task automatic take_rx_byte(input logic [7:0] b);
		logic [7:0] expected;
		if (expected_q.size() == 0) begin
			$display("received byte %h while no transmitted byte was outstanding", b);
			$display("Regression failed");
			$fatal(1, "unexpected receive byte");
		end else begin
			expected = expected_q.pop_front();
			check_value("rx_data", b, expected);
		end
	endtask

	task automatic make_packet(input bit with_ff);
		int len;
		int pos;
		len = $urandom_range(1, max_len);
		pkt.delete();
		repeat (len)
			pkt.push_back(8'($urandom()));
		// a run of ones forces a stuffed bit
		if (with_ff) begin
			pos = $urandom_range(0, len - 1);
			pkt[pos] = 8'hFF;
		end
	endtask

	// feeds tx and drains rx over the bus until the packet is back
	task automatic run_packet();
		int n;
		int sent;
		int got;
		bit valid_cleared;
		logic [7:0] flag;
		logic [7:0] rx_byte;
		n = pkt.size();
		write_reg(REG_TX_DATA, pkt[0]);
		sent = 1;
		got = 0;
		valid_cleared = 1'b0;
		while (got < n) begin
			read_reg(REG_RX_PENDING, flag);
			if (flag == 8'd1) begin
				read_reg(REG_RX_DATA, rx_byte);
				take_rx_byte(rx_byte);
				got++;
			end
			if (!valid_cleared) begin
				read_reg(REG_TX_PENDING, flag);
				if (flag == 8'd0 && sent < n) begin
					write_reg(REG_TX_DATA, pkt[sent]);
					sent++;
				end else if (flag == 8'd0) begin
					write_reg(REG_TX_VALID, 8'd0);
					valid_cleared = 1'b1;
				end
			end
		end
		poll_flag(REG_RX_ACTIVE, 8'd0);
		read_reg(REG_RX_ERROR, flag);
		check_value("rx_error", flag, 8'd0);
		check_value("outstanding bytes", 8'(expected_q.size()), 8'd0);
		while (usba_oe_n_o == 1'b0)
			tick();
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		logic [7:0] v;
		sie_reg_e reg_id;
		void'($urandom(32'h52e3));
		rst_n_i = 1'b0;
		zpu_re_i = 1'b0;
		zpu_we_i = 1'b0;
		zpu_a_i = '0;
		zpu_dat_i = '0;
		force_se0 = 1'b0;
		repeat (2) @(posedge usb_clk);
		#drive_delay;
		rst_n_i = 1'b1;

		// reset values, idle lines read J
		for (int r = 0; r < 14; r++) begin
			reg_id = sie_reg_e'(r);
			read_reg(reg_id, v);
			check_value(reg_id.name(), v, (r < 2) ? {6'b0, LINE_J} : 8'd0);
		end
		check_value("usba_oe_n_o", {7'b0, usba_oe_n_o}, 8'd1);
		check_value("usbb_oe_n_o", {7'b0, usbb_oe_n_o}, 8'd1);
		// full speed on both ports
		check_value("usba_spd_o", {7'b0, usba_spd_o}, 8'd1);
		check_value("usbb_spd_o", {7'b0, usbb_spd_o}, 8'd1);

		// read back of control registers
		write_reg(REG_SEL_RX, 8'd1);
		read_reg(REG_SEL_RX, v);
		check_value("sel_rx", v, 8'd1);
		for (int s = 0; s < 4; s++) begin
			write_reg(REG_SEL_TX, 8'(s));
			read_reg(REG_SEL_TX, v);
			check_value("sel_tx", v, 8'(s));
		end
		write_reg(REG_SEL_TX, 8'd0);
		write_reg(REG_GEN_RESET, 8'd1);
		read_reg(REG_GEN_RESET, v);
		check_value("gen_reset", v, 8'd1);
		write_reg(REG_GEN_RESET, 8'd0);
		read_reg(REG_GEN_RESET, v);
		check_value("gen_reset", v, 8'd0);

		// random packets from A to B
		write_reg(REG_SEL_TX, 8'd1);
		write_reg(REG_SEL_RX, 8'd1);
		for (int p = 0; p < num_packets; p++) begin
			make_packet(p % 2 == 0);
			run_packet();
		end

		// SE0 in the middle of a byte
		write_reg(REG_TX_DATA, 8'hA5);
		poll_flag(REG_TX_PENDING, 8'd0);
		write_reg(REG_TX_VALID, 8'd0);
		poll_flag(REG_RX_ACTIVE, 8'd1);
		repeat (3 * `SOFTUSB_OVERSAMPLE) tick();
		force_se0 = 1'b1;
		while (usba_oe_n_o == 1'b0)
			tick();
		repeat (`SOFTUSB_OVERSAMPLE) tick();
		force_se0 = 1'b0;
		read_reg(REG_RX_ERROR, v);
		check_value("rx_error", v, 8'd1);
		read_reg(REG_RX_ACTIVE, v);
		check_value("rx_active", v, 8'd0);
		read_reg(REG_RX_PENDING, v);
		check_value("rx_pending", v, 8'd0);
		// the cut byte never arrives
		expected_q.delete();
		make_packet(1'b0);
		run_packet();

		// long SE0 on B is a disconnect
		force_se0 = 1'b1;
		repeat (200) tick();
		read_reg(REG_DISCON_B, v);
		check_value("discon_b", v, 8'd1);
		read_reg(REG_LINE_B, v);
		check_value("line_b", v, {6'b0, LINE_SE0});
		read_reg(REG_DISCON_A, v);
		check_value("discon_a", v, 8'd0);
		force_se0 = 1'b0;
		repeat (2 * `SOFTUSB_OVERSAMPLE) tick();
		read_reg(REG_DISCON_B, v);
		check_value("discon_b", v, 8'd0);
		read_reg(REG_LINE_B, v);
		check_value("line_b", v, {6'b0, LINE_J});

		// bus reset drive on A
		write_reg(REG_GEN_RESET, 8'd1);
		repeat (4) tick();
		read_reg(REG_LINE_B, v);
		check_value("line_b", v, {6'b0, LINE_SE0});
		check_value("usba_oe_n_o", {7'b0, usba_oe_n_o}, 8'd0);
		write_reg(REG_GEN_RESET, 8'd0);
		repeat (4) tick();
		read_reg(REG_LINE_B, v);
		check_value("line_b", v, {6'b0, LINE_J});
		check_value("usba_oe_n_o", {7'b0, usba_oe_n_o}, 8'd1);

		$display("Regression passed");
		$finish;
	end

endmodule
